// File: Makefile
# Verilator build and run for the APB peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_periph
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up as a line of its own
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/periph_pkg.sv
/*
 * Shared constants for the APB peripheral subsystem.
 * Address bits 15:12 pick the block and bits 11:0 the register offset.
 * All registers are 32-bit words and only word offsets are decoded.
 */

package periph_pkg;

    localparam int DataWidth   = 32;
    localparam int AddrWidth   = 16;
    localparam int OffsetWidth = 12;   // Offset bits below the slot field

    typedef logic [DataWidth-1:0]             data_t;
    typedef logic [AddrWidth-1:0]             addr_t;
    typedef logic [OffsetWidth-1:0]           offset_t;
    typedef logic [AddrWidth-OffsetWidth-1:0] slot_t;

    // ----------------------------------------
    // Address slots
    // ----------------------------------------
    localparam slot_t SlotIrq   = 'd0;
    localparam slot_t SlotTimer = 'd1;
    localparam slot_t SlotGpio  = 'd2;

    // Timer bank, one stride per timer
    localparam int      TimerStride   = 16;
    localparam offset_t TimerCtrlOff  = 'h0;   // Bit 0 is the enable
    localparam offset_t TimerCountOff = 'h4;
    localparam offset_t TimerCmpOff   = 'h8;

    // GPIO
    localparam offset_t GpioLedOff = 'h0;
    localparam offset_t GpioSwOff  = 'h4;   // Read only

    // Interrupt controller
    localparam offset_t IrqEnableOff  = 'h0;
    localparam offset_t IrqPendingOff = 'h4;   // Read only
    localparam offset_t IrqClaimOff   = 'h8;   // Read clears the claimed source

    // Read value for unmapped space
    localparam data_t ErrorData = 32'hdead_beef;

endpackage

// File: gpio/apb_gpio.sv
/*
 * LED output register and DIP switch input.
 * Switches go through two flops; any change of the synchronized value
 * pulses irq_o one cycle later. Writes to the switch word are dropped.
 */
`timescale 1ns/1ps

module apb_gpio import periph_pkg::*; #(
    parameter int LedWidth    = 8,
    parameter int SwitchWidth = 8
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   sel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  offset_t                addr_i,
    input  data_t                  wdata_i,
    input  logic [SwitchWidth-1:0] switches_i,
    output data_t                  rdata_o,
    output logic                   bad_offset_o,
    output logic [LedWidth-1:0]    leds_o,
    output logic                   irq_o
);

    logic [LedWidth-1:0]    led_q;
    logic [SwitchWidth-1:0] sw_meta_q;
    logic [SwitchWidth-1:0] sw_sync_q;
    logic [SwitchWidth-1:0] sw_prev_q;
    logic                   irq_q;
    logic                   is_led;
    logic                   is_sw;
    logic                   led_wr;

    assign is_led = (addr_i == GpioLedOff);
    assign is_sw  = (addr_i == GpioSwOff);
    assign led_wr = sel_i & penable_i & pwrite_i & is_led;

    assign bad_offset_o = sel_i & ~(is_led | is_sw);

    always_comb begin
        rdata_o = '0;
        if (is_led) begin
            rdata_o = data_t'(led_q);
        end else if (is_sw) begin
            rdata_o = data_t'(sw_sync_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            led_q     <= '0;
            sw_meta_q <= '0;
            sw_sync_q <= '0;
            sw_prev_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            if (led_wr) led_q <= wdata_i[LedWidth-1:0];
            sw_meta_q <= switches_i;   // Async input
            sw_sync_q <= sw_meta_q;
            sw_prev_q <= sw_sync_q;
            irq_q     <= |(sw_sync_q ^ sw_prev_q);
        end
    end

    assign leds_o = led_q;
    assign irq_o  = irq_q;

endmodule

// File: logic/apb_decoder.sv
/*
 * APB slot decoder. Zero wait states, pready_o follows the access cycle.
 * Only the slot is checked here; blocks flag bad offsets themselves.
 */
`timescale 1ns/1ps

module apb_decoder import periph_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  psel_i,
    input  logic  penable_i,
    input  addr_t paddr_i,
    input  data_t irq_rdata_i,
    input  data_t timer_rdata_i,
    input  data_t gpio_rdata_i,
    input  logic  bad_offset_i,
    output logic  sel_irq_o,
    output logic  sel_timer_o,
    output logic  sel_gpio_o,
    output data_t prdata_o,
    output logic  pready_o,
    output logic  pslverr_o
);

    slot_t slot;
    logic  mapped;
    logic  access;

    assign slot   = paddr_i[AddrWidth-1:OffsetWidth];
    assign access = psel_i & penable_i;

    always_comb begin
        sel_irq_o   = 1'b0;
        sel_timer_o = 1'b0;
        sel_gpio_o  = 1'b0;
        mapped      = 1'b1;
        prdata_o    = ErrorData;
        case (slot)
            SlotIrq: begin
                sel_irq_o = psel_i;
                prdata_o  = irq_rdata_i;
            end
            SlotTimer: begin
                sel_timer_o = psel_i;
                prdata_o    = timer_rdata_i;
            end
            SlotGpio: begin
                sel_gpio_o = psel_i;
                prdata_o   = gpio_rdata_i;
            end
            default: mapped = 1'b0;
        endcase
        if (bad_offset_i) prdata_o = ErrorData;   // Block rejected the offset
    end

    assign pready_o  = access;
    assign pslverr_o = access & (~mapped | bad_offset_i);

    // Access phase must come right after a setup phase to the same address
    a_setup_before_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && penable_i) |-> ($past(psel_i && !penable_i) && $stable(paddr_i)))
        else $error("APB access cycle without matching setup cycle");

endmodule

// File: logic/periph_top.sv
/*
 * Peripheral subsystem top: APB decoder, timers, GPIO, interrupt controller.
 * Interrupt IDs: timers 1..NumTimers, GPIO NumTimers+1.
 */
`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
    parameter int NumTimers   = 2,
    parameter int LedWidth    = 8,
    parameter int SwitchWidth = 8
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  addr_t                  paddr_i,
    input  data_t                  pwdata_i,
    input  logic [SwitchWidth-1:0] switches_i,
    output data_t                  prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   irq_o,
    output logic [LedWidth-1:0]    leds_o
);

    localparam int NumSources = NumTimers + 1;

    logic                  sel_irq;
    logic                  sel_timer;
    logic                  sel_gpio;
    data_t                 irq_rdata;
    data_t                 timer_rdata;
    data_t                 gpio_rdata;
    logic                  irq_bad;
    logic                  timer_bad;
    logic                  gpio_bad;
    logic [NumTimers-1:0]  timer_irq;
    logic                  gpio_irq;
    logic [NumSources-1:0] sources;

    assign sources = {gpio_irq, timer_irq};

    apb_decoder i_decoder (
        .clk_i         ( clk_i                            ),
        .rst_n_i       ( rst_n_i                          ),
        .psel_i        ( psel_i                           ),
        .penable_i     ( penable_i                        ),
        .paddr_i       ( paddr_i                          ),
        .irq_rdata_i   ( irq_rdata                        ),
        .timer_rdata_i ( timer_rdata                      ),
        .gpio_rdata_i  ( gpio_rdata                       ),
        .bad_offset_i  ( irq_bad | timer_bad | gpio_bad   ),
        .sel_irq_o     ( sel_irq                          ),
        .sel_timer_o   ( sel_timer                        ),
        .sel_gpio_o    ( sel_gpio                         ),
        .prdata_o      ( prdata_o                         ),
        .pready_o      ( pready_o                         ),
        .pslverr_o     ( pslverr_o                        )
    );

    apb_timer #(
        .NumTimers ( NumTimers )
    ) i_timer (
        .clk_i        ( clk_i                        ),
        .rst_n_i      ( rst_n_i                      ),
        .sel_i        ( sel_timer                    ),
        .penable_i    ( penable_i                    ),
        .pwrite_i     ( pwrite_i                     ),
        .addr_i       ( paddr_i[OffsetWidth-1:0]     ),
        .wdata_i      ( pwdata_i                     ),
        .rdata_o      ( timer_rdata                  ),
        .bad_offset_o ( timer_bad                    ),
        .irq_o        ( timer_irq                    )
    );

    apb_gpio #(
        .LedWidth    ( LedWidth    ),
        .SwitchWidth ( SwitchWidth )
    ) i_gpio (
        .clk_i        ( clk_i                        ),
        .rst_n_i      ( rst_n_i                      ),
        .sel_i        ( sel_gpio                     ),
        .penable_i    ( penable_i                    ),
        .pwrite_i     ( pwrite_i                     ),
        .addr_i       ( paddr_i[OffsetWidth-1:0]     ),
        .wdata_i      ( pwdata_i                     ),
        .switches_i   ( switches_i                   ),
        .rdata_o      ( gpio_rdata                   ),
        .bad_offset_o ( gpio_bad                     ),
        .leds_o       ( leds_o                       ),
        .irq_o        ( gpio_irq                     )
    );

    irq_ctrl #(
        .NumSources ( NumSources )
    ) i_irq_ctrl (
        .clk_i        ( clk_i                        ),
        .rst_n_i      ( rst_n_i                      ),
        .sel_i        ( sel_irq                      ),
        .penable_i    ( penable_i                    ),
        .pwrite_i     ( pwrite_i                     ),
        .addr_i       ( paddr_i[OffsetWidth-1:0]     ),
        .wdata_i      ( pwdata_i                     ),
        .sources_i    ( sources                      ),
        .rdata_o      ( irq_rdata                    ),
        .bad_offset_o ( irq_bad                      ),
        .irq_o        ( irq_o                        )
    );

endmodule

// File: plic/irq_ctrl.sv
/*
 * Single-target interrupt controller, edge sources only, no priorities.
 * Source IDs start at 1; a claim read returns the lowest pending and
 * enabled ID, or 0, and clears that pending bit unless it pulses again.
 */
`timescale 1ns/1ps

module irq_ctrl import periph_pkg::*; #(
    parameter int NumSources = 3
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  sel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  offset_t               addr_i,
    input  data_t                 wdata_i,
    input  logic [NumSources-1:0] sources_i,
    output data_t                 rdata_o,
    output logic                  bad_offset_o,
    output logic                  irq_o
);

    logic [NumSources-1:0] enable_q;
    logic [NumSources-1:0] pending_q;
    logic [NumSources-1:0] active;
    logic [NumSources-1:0] claim_mask;
    data_t                 claim_id;
    logic                  irq_q;
    logic                  access;
    logic                  enable_wr;
    logic                  claim_rd;

    assign active    = pending_q & enable_q;
    assign access    = sel_i & penable_i;
    assign enable_wr = access & pwrite_i & (addr_i == IrqEnableOff);
    assign claim_rd  = access & ~pwrite_i & (addr_i == IrqClaimOff);

    assign bad_offset_o = sel_i & ~((addr_i == IrqEnableOff)  ||
                                    (addr_i == IrqPendingOff) ||
                                    (addr_i == IrqClaimOff));

    // Scan downwards so the lowest active source is left standing
    always_comb begin
        claim_id   = '0;
        claim_mask = '0;
        for (int i = NumSources - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id   = data_t'(i + 1);
                claim_mask = NumSources'(1) << i;
            end
        end
    end

    always_comb begin
        case (addr_i)
            IrqEnableOff:  rdata_o = data_t'(enable_q);
            IrqPendingOff: rdata_o = data_t'(pending_q);
            IrqClaimOff:   rdata_o = claim_id;
            default:       rdata_o = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q  <= '0;
            pending_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            if (enable_wr) enable_q <= wdata_i[NumSources-1:0];
            // A new pulse beats a claim of the same source
            pending_q <= (pending_q & ~({NumSources{claim_rd}} & claim_mask)) | sources_i;
            irq_q     <= |active;
        end
    end

    assign irq_o = irq_q;

    // irq_o is high one cycle after a claim would find a pending, enabled source
    a_irq_follows_claim: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_o == $past(claim_id != '0))
        else $error("irq_o disagrees with the claim result");

endmodule

// File: tests/tb_periph.sv
/*
 * Table-driven testbench for periph_top with its default parameters.
 * Each step starts and ends on a falling edge. APB outputs are sampled
 * a quarter period into the access cycle.
 */
`timescale 1ns/1ps

module tb_periph import periph_pkg::*; ();

    localparam int    ClkPeriod    = 100;
    localparam int    NumTimers    = 2;
    localparam int    LedWidth     = 8;
    localparam int    SwitchWidth  = 8;
    localparam int    IdGpio       = NumTimers + 1;
    localparam data_t Timer1Mask   = data_t'(1 << 1);   // Source ID 2
    localparam data_t GpioMask     = data_t'(1 << (IdGpio - 1));
    localparam data_t AllMask      = data_t'((1 << (NumTimers + 1)) - 1);
    localparam addr_t EnableAddr   = {SlotIrq, IrqEnableOff};
    localparam addr_t PendingAddr  = {SlotIrq, IrqPendingOff};
    localparam addr_t ClaimAddr    = {SlotIrq, IrqClaimOff};
    localparam addr_t LedAddr      = {SlotGpio, GpioLedOff};
    localparam addr_t SwAddr       = {SlotGpio, GpioSwOff};
    localparam addr_t UnmappedAddr = 16'h3000;   // Slot 3

    typedef enum logic [2:0] {
        OpWrite,
        OpRead,
        OpWaitIrq,   // data holds the timeout in cycles
        OpSwitch,
        OpIrq,       // exp holds the irq_o level
        OpLeds
    } op_e;

    typedef struct packed {
        int    test;
        op_e   op;
        addr_t addr;
        data_t data;
        data_t exp;
        logic  exp_err;
    } step_t;

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    addr_t                  paddr;
    data_t                  pwdata;
    logic [SwitchWidth-1:0] switches;
    data_t                  prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   irq;
    logic [LedWidth-1:0]    leds;

    step_t steps [$];
    string names [5] = '{"reset", "gpio", "errors", "timer irq", "mask and claim"};
    int    checks;
    int    errors;

    periph_top #(
        .NumTimers   ( NumTimers   ),
        .LedWidth    ( LedWidth    ),
        .SwitchWidth ( SwitchWidth )
    ) uut (
        .clk_i      ( clk      ),
        .rst_n_i    ( rst_n    ),
        .psel_i     ( psel     ),
        .penable_i  ( penable  ),
        .pwrite_i   ( pwrite   ),
        .paddr_i    ( paddr    ),
        .pwdata_i   ( pwdata   ),
        .switches_i ( switches ),
        .prdata_o   ( prdata   ),
        .pready_o   ( pready   ),
        .pslverr_o  ( pslverr  ),
        .irq_o      ( irq      ),
        .leds_o     ( leds     )
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic addr_t timer_reg(input int t, input offset_t off);
        return {SlotTimer, offset_t'(t * TimerStride) | off};
    endfunction

    task automatic check(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ----------------------------------------
    // APB transfers, two cycles each
    // ----------------------------------------
    task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(ClkPeriod / 4);
        check("pready_o", data_t'(pready), 32'd1);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t data, output logic err);
        data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input addr_t addr, output data_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic wait_irq(input int limit);
        int n;
        n = 0;
        while (!irq && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (!irq) begin
            errors++;
            $display("Timeout: irq_o did not rise within %0d cycles", limit);
        end
    endtask

    task automatic add_step(input int test, input op_e op, input addr_t addr,
                            input data_t data, input data_t exp, input logic exp_err);
        step_t s;
        s.test    = test;
        s.op      = op;
        s.addr    = addr;
        s.data    = data;
        s.exp     = exp;
        s.exp_err = exp_err;
        steps.push_back(s);
    endtask

    task automatic run_step(input step_t s);
        data_t rdata;
        logic  err;
        case (s.op)
            OpWrite: begin
                apb_write(s.addr, s.data, err);
                check("pslverr_o", data_t'(err), data_t'(s.exp_err));
            end
            OpRead: begin
                apb_read(s.addr, rdata, err);
                check("prdata_o", rdata, s.exp);
                check("pslverr_o", data_t'(err), data_t'(s.exp_err));
            end
            OpWaitIrq: wait_irq(int'(s.data));
            OpSwitch: begin
                switches = s.data[SwitchWidth-1:0];
                repeat (5) @(negedge clk);   // Through the synchronizer
            end
            OpIrq:   check("irq_o", data_t'(irq), s.exp);
            default: check("leds_o", data_t'(leds), s.exp);
        endcase
    endtask

    // ----------------------------------------
    // Step table
    // ----------------------------------------
    task automatic fill_table();
        add_step(0, OpIrq,     '0,                          '0,      '0,          1'b0);
        add_step(0, OpLeds,    '0,                          '0,      '0,          1'b0);
        add_step(0, OpRead,    timer_reg(0, TimerCtrlOff),  '0,      '0,          1'b0);
        add_step(0, OpRead,    EnableAddr,                  '0,      '0,          1'b0);
        add_step(0, OpRead,    PendingAddr,                 '0,      '0,          1'b0);
        add_step(1, OpWrite,   LedAddr,                     'ha5,    '0,          1'b0);
        add_step(1, OpLeds,    '0,                          '0,      'ha5,        1'b0);
        add_step(1, OpRead,    LedAddr,                     '0,      'ha5,        1'b0);
        add_step(1, OpSwitch,  '0,                          'h3c,    '0,          1'b0);
        add_step(1, OpRead,    SwAddr,                      '0,      'h3c,        1'b0);
        add_step(1, OpWrite,   SwAddr,                      'hff,    '0,          1'b0);
        add_step(1, OpRead,    SwAddr,                      '0,      'h3c,        1'b0);
        add_step(2, OpRead,    UnmappedAddr,                '0,      ErrorData,   1'b1);
        add_step(2, OpRead,    timer_reg(0, offset_t'('hc)), '0,     ErrorData,   1'b1);
        add_step(2, OpRead,    timer_reg(NumTimers, TimerCtrlOff), '0, ErrorData, 1'b1);
        add_step(2, OpWrite,   UnmappedAddr,                '1,      '0,          1'b1);
        add_step(2, OpRead,    LedAddr,                     '0,      'ha5,        1'b0);
        add_step(2, OpRead,    EnableAddr,                  '0,      '0,          1'b0);
        add_step(2, OpRead,    timer_reg(0, TimerCtrlOff),  '0,      '0,          1'b0);
        add_step(3, OpWrite,   EnableAddr,                  'h1,     '0,          1'b0);
        add_step(3, OpWrite,   timer_reg(0, TimerCmpOff),   'd20,    '0,          1'b0);
        add_step(3, OpWrite,   timer_reg(0, TimerCtrlOff),  'h1,     '0,          1'b0);
        add_step(3, OpWaitIrq, '0,                          'd40,    '0,          1'b0);
        add_step(3, OpWrite,   timer_reg(0, TimerCtrlOff),  'h0,     '0,          1'b0);
        add_step(3, OpRead,    ClaimAddr,                   '0,      'd1,         1'b0);
        add_step(3, OpRead,    ClaimAddr,                   '0,      '0,          1'b0);
        add_step(3, OpIrq,     '0,                          '0,      '0,          1'b0);
        // GPIO still pending from the switch test
        add_step(4, OpWrite,   EnableAddr,                  GpioMask, '0,         1'b0);
        add_step(4, OpRead,    ClaimAddr,                   '0,      data_t'(IdGpio), 1'b0);
        add_step(4, OpRead,    ClaimAddr,                   '0,      '0,          1'b0);
        add_step(4, OpIrq,     '0,                          '0,      '0,          1'b0);
        add_step(4, OpWrite,   timer_reg(1, TimerCmpOff),   'd3,     '0,          1'b0);
        add_step(4, OpWrite,   timer_reg(1, TimerCtrlOff),  'h1,     '0,          1'b0);
        add_step(4, OpRead,    timer_reg(1, TimerCmpOff),   '0,      'd3,         1'b0);
        add_step(4, OpRead,    timer_reg(1, TimerCtrlOff),  '0,      'h1,         1'b0);
        add_step(4, OpRead,    PendingAddr,                 '0,      Timer1Mask,  1'b0);
        add_step(4, OpIrq,     '0,                          '0,      '0,          1'b0);   // Masked
        add_step(4, OpSwitch,  '0,                          'h3d,    '0,          1'b0);
        add_step(4, OpWaitIrq, '0,                          'd10,    '0,          1'b0);
        add_step(4, OpRead,    PendingAddr,                 '0,      Timer1Mask | GpioMask, 1'b0);
        add_step(4, OpWrite,   timer_reg(1, TimerCtrlOff),  'h0,     '0,          1'b0);
        add_step(4, OpWrite,   EnableAddr,                  AllMask, '0,          1'b0);
        add_step(4, OpRead,    ClaimAddr,                   '0,      'd2,         1'b0);
        add_step(4, OpRead,    ClaimAddr,                   '0,      data_t'(IdGpio), 1'b0);
        add_step(4, OpRead,    ClaimAddr,                   '0,      '0,          1'b0);
        add_step(4, OpIrq,     '0,                          '0,      '0,          1'b0);
    endtask

    initial begin
        int first;
        checks   = 0;
        errors   = 0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        switches = '0;
        fill_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        first = errors;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                $display("Test %0d %s: %s, %0d errors", steps[i].test, names[steps[i].test],
                         (errors == first) ? "passed" : "failed", errors - first);
                first = errors;
            end
        end

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: timer/apb_timer.sv
/*
 * Bank of free-running compare timers, TimerStride bytes per timer.
 * An enabled timer counts up and wraps to 0 after it matches compare,
 * so irq_o[t] pulses for one cycle every compare+1 cycles.
 */
`timescale 1ns/1ps

module apb_timer import periph_pkg::*; #(
    parameter int NumTimers = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 sel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  offset_t              addr_i,
    input  data_t                wdata_i,
    output data_t                rdata_o,
    output logic                 bad_offset_o,
    output logic [NumTimers-1:0] irq_o
);

    localparam int StrideBits = $clog2(TimerStride);
    localparam int IdxWidth   = OffsetWidth - StrideBits;

    logic [IdxWidth-1:0]   idx;
    logic [StrideBits-1:0] word;
    logic [NumTimers-1:0]  hit;   // One-hot timer select
    logic                  word_ok;
    logic                  wr_en;

    logic [NumTimers-1:0] en_q;
    data_t                count_q [NumTimers];
    data_t                cmp_q   [NumTimers];

    assign idx  = addr_i[OffsetWidth-1:StrideBits];
    assign word = addr_i[StrideBits-1:0];

    assign word_ok = (word == TimerCtrlOff[StrideBits-1:0])  ||
                     (word == TimerCountOff[StrideBits-1:0]) ||
                     (word == TimerCmpOff[StrideBits-1:0]);

    assign bad_offset_o = sel_i & ~((|hit) & word_ok);
    assign wr_en        = sel_i & penable_i & pwrite_i & (|hit) & word_ok;

    // ----------------------------------------
    // Timer select, read mux and match
    // ----------------------------------------
    always_comb begin
        rdata_o = '0;
        for (int t = 0; t < NumTimers; t++) begin
            hit[t]   = (idx == IdxWidth'(t));
            irq_o[t] = en_q[t] && (count_q[t] == cmp_q[t]);
            if (hit[t]) begin
                if (word == TimerCtrlOff[StrideBits-1:0]) begin
                    rdata_o = data_t'(en_q[t]);
                end else if (word == TimerCountOff[StrideBits-1:0]) begin
                    rdata_o = count_q[t];
                end else if (word == TimerCmpOff[StrideBits-1:0]) begin
                    rdata_o = cmp_q[t];
                end
            end
        end
    end

    // ----------------------------------------
    // Counters and register writes
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            en_q <= '0;
            for (int t = 0; t < NumTimers; t++) begin
                count_q[t] <= '0;
                cmp_q[t]   <= '0;
            end
        end else begin
            for (int t = 0; t < NumTimers; t++) begin
                if (irq_o[t]) begin
                    count_q[t] <= '0;   // Wrap on match
                end else if (en_q[t]) begin
                    count_q[t] <= count_q[t] + 1'b1;
                end
                // Software write overrides counting
                if (wr_en && hit[t]) begin
                    if (word == TimerCtrlOff[StrideBits-1:0])  en_q[t]    <= wdata_i[0];
                    if (word == TimerCountOff[StrideBits-1:0]) count_q[t] <= wdata_i;
                    if (word == TimerCmpOff[StrideBits-1:0])   cmp_q[t]   <= wdata_i;
                end
            end
        end
    end

endmodule

// File: vlog.f
common/periph_pkg.sv
logic/apb_decoder.sv
timer/apb_timer.sv
gpio/apb_gpio.sv
plic/irq_ctrl.sv
logic/periph_top.sv
tests/tb_periph.sv
